//--- logic/spi_flash_pkg.sv
`default_nettype none

package spi_flash_pkg;

    localparam int CLKS_PER_HALF_SCLK = 2;
    localparam int NUM_LANES          = 4;
    localparam int APB_ADDR_W         = 8;
    localparam int DATA_W             = 32;
    localparam int FL_ADDR_W          = 24;

    // One extra bit above the data for the capture marker
    localparam int CAP_W = DATA_W + 1;

    localparam logic [APB_ADDR_W-1:0] REG_CMD    = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_ADDR   = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_WDATA  = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h10;
    localparam logic [APB_ADDR_W-1:0] REG_RDATA  = 8'h14;

    typedef enum logic [1:0] {
        FRAME_CMD,
        FRAME_READ,
        FRAME_WRITE
    } frame_type_e;

    typedef enum logic {
        LANE_SINGLE,
        LANE_QUAD
    } lane_mode_e;

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        DUMMY,
        DATA,
        DONE
    } seq_phase_e;

    // REG_CMD holds opcode [7:0], type [9:8], mode [10], dummy [14:11] and count-1 [16:15]
    typedef struct packed {
        logic [1:0]  nbytes_m1;
        logic [3:0]  dummy;
        lane_mode_e  mode;
        frame_type_e ftype;
        logic [7:0]  opcode;
    } flash_cmd_t;

    typedef struct packed {
        logic              load;
        logic [DATA_W-1:0] word;
        logic              shift;
        logic              sample;
        logic              oe_req;
    } lane_ctrl_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [DATA_W-1:0]     pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

//--- logic/spi_flash_regs.sv
`timescale 1ns/1ns
`default_nettype none

module spi_flash_regs
    import spi_flash_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  apb_req_t             apb,
    input  logic                 busy,
    input  logic                 done,
    input  logic [DATA_W-1:0]    rdata_word,
    output logic [DATA_W-1:0]    prdata,
    output logic                 pready,
    output logic                 pslverr,
    output flash_cmd_t           cmd,
    output logic [FL_ADDR_W-1:0] flash_addr,
    output logic [DATA_W-1:0]    wdata_word,
    output logic                 start
);

    logic              access;
    logic              wr;
    logic              mapped;
    logic              ctrl_go;
    logic              done_q;
    logic [DATA_W-1:0] rdata_q;

    assign access  = apb.psel && apb.penable;
    assign wr      = access && apb.pwrite;
    assign ctrl_go = wr && apb.paddr == REG_CTRL && apb.pwdata[0];
    assign pready  = 1'b1;

    // Start request during a frame is refused
    assign pslverr = access && (!mapped || (ctrl_go && (busy || start)));

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (apb.paddr)
            REG_CMD:    prdata = DATA_W'(cmd);
            REG_ADDR:   prdata = DATA_W'(flash_addr);
            REG_WDATA:  prdata = wdata_word;
            REG_CTRL:   prdata = '0;
            REG_STATUS: prdata = DATA_W'({done_q, busy});
            REG_RDATA:  prdata = rdata_q;
            default:    mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd        <= '0;
            flash_addr <= '0;
            wdata_word <= '0;
            rdata_q    <= '0;
            done_q     <= 1'b0;
            start      <= 1'b0;
        end else begin
            start <= ctrl_go && !busy && !start;
            if (done)
                rdata_q <= rdata_word;
            // Sticky done cleared by any CTRL write
            if (done)
                done_q <= 1'b1;
            else if (wr && apb.paddr == REG_CTRL)
                done_q <= 1'b0;
            // Frame setup held stable while a frame runs
            if (wr && !busy) begin
                case (apb.paddr)
                    REG_CMD:   cmd <= flash_cmd_t'(apb.pwdata[$bits(flash_cmd_t)-1:0]);
                    REG_ADDR:  flash_addr <= apb.pwdata[FL_ADDR_W-1:0];
                    REG_WDATA: wdata_word <= apb.pwdata;
                    default:   ;
                endcase
            end
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

//--- logic/spi_frame_seq.sv
`timescale 1ns/1ns
`default_nettype none

module spi_frame_seq
    import spi_flash_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  flash_cmd_t           cmd,
    input  logic [FL_ADDR_W-1:0] flash_addr,
    input  logic [DATA_W-1:0]    wdata_word,
    output logic                 busy,
    output logic                 done,
    output logic                 sclk,
    output logic                 ss_n,
    output lane_ctrl_t           lane_ctrl [NUM_LANES],
    output lane_mode_e           lane_mode,
    output logic                 capture_done
);

    seq_phase_e phase;
    seq_phase_e nxt_phase;
    seq_phase_e load_phase;
    logic [3:0] div_cnt;
    logic [5:0] bits_left;
    logic       tick;
    logic       rise;
    logic       fall;
    logic       phase_end;
    logic       load;
    logic       quad;
    logic       wr_frame;

    assign quad     = cmd.mode == LANE_QUAD;
    assign wr_frame = cmd.ftype == FRAME_WRITE;

    // SCLK count of a phase
    function automatic logic [5:0] phase_len(input seq_phase_e ph);
        logic [5:0] nbytes;
        nbytes = 6'(cmd.nbytes_m1) + 6'd1;
        case (ph)
            CMD:     return 6'd8;
            ADDR:    return quad ? 6'd6 : 6'd24;
            DUMMY:   return 6'(cmd.dummy);
            DATA:    return quad ? nbytes << 1 : nbytes << 3;
            default: return 6'd0;
        endcase
    endfunction

    function automatic seq_phase_e next_of(input seq_phase_e ph);
        case (ph)
            CMD:     return (cmd.ftype == FRAME_READ || wr_frame) ? ADDR : DONE;
            ADDR:    return (!wr_frame && cmd.dummy != 4'd0) ? DUMMY : DATA;
            DUMMY:   return DATA;
            default: return DONE;
        endcase
    endfunction

    // Lane k carries bit k of every nibble with DQ3 highest
    function automatic logic [DATA_W-1:0] spread(input logic [DATA_W-1:0] bits, input int lane);
        logic [DATA_W-1:0] w;
        w = '0;
        for (int i = 0; i < DATA_W / 4; i++)
            w[DATA_W-1-i] = bits[DATA_W-4-4*i+lane];
        return w;
    endfunction

    function automatic logic [DATA_W-1:0] lane_word(input seq_phase_e ph, input int lane);
        logic [DATA_W-1:0] bits;
        case (ph)
            CMD:     bits = {cmd.opcode, {(DATA_W-8){1'b0}}};
            ADDR:    bits = {flash_addr, {(DATA_W-FL_ADDR_W){1'b0}}};
            // Low byte goes out first
            DATA:    bits = wr_frame ? {wdata_word[7:0], wdata_word[15:8],
                                        wdata_word[23:16], wdata_word[31:24]} : '0;
            default: bits = '0;
        endcase
        if (quad && ph != CMD)
            return spread(bits, lane);
        return (lane == 0) ? bits : '0;
    endfunction

    function automatic logic lane_oe(input seq_phase_e ph, input int lane);
        if (ph == CMD)
            return lane == 0;
        if (ph == ADDR || (ph == DATA && wr_frame))
            return quad || lane == 0;
        return 1'b0;
    endfunction

    assign tick         = busy && div_cnt == 4'(CLKS_PER_HALF_SCLK - 1);
    assign rise         = tick && !sclk && phase != DONE;
    assign fall         = tick && sclk;
    assign phase_end    = fall && bits_left == 6'd1;
    assign nxt_phase    = next_of(phase);
    assign load         = start || phase_end;
    assign load_phase   = start ? CMD : nxt_phase;
    assign capture_done = phase_end && phase == DATA && cmd.ftype == FRAME_READ;
    assign lane_mode    = cmd.mode;

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_ctrl[k].load   = load;
            lane_ctrl[k].word   = lane_word(load_phase, k);
            lane_ctrl[k].shift  = fall;
            lane_ctrl[k].sample = rise;
            lane_ctrl[k].oe_req = lane_oe(load ? load_phase : phase, k);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            sclk      <= 1'b0;
            ss_n      <= 1'b1;
            div_cnt   <= '0;
            bits_left <= '0;
        end else begin
            done    <= 1'b0;
            div_cnt <= (tick || !busy) ? 4'd0 : div_cnt + 4'd1;
            if (rise)
                sclk <= 1'b1;
            if (fall) begin
                sclk      <= 1'b0;
                bits_left <= phase_end ? phase_len(nxt_phase) : bits_left - 6'd1;
                if (phase_end)
                    phase <= nxt_phase;
            end
            // First half period doubles as chip select setup
            if (phase == IDLE && start) begin
                phase     <= CMD;
                busy      <= 1'b1;
                ss_n      <= 1'b0;
                bits_left <= phase_len(CMD);
            end
            // Hold of one half period after the last falling edge
            if (phase == DONE && tick) begin
                phase <= IDLE;
                busy  <= 1'b0;
                ss_n  <= 1'b1;
                done  <= 1'b1;
            end
        end
    end

    // SCLK rests low whenever the chip is deselected
    a_sclk_idle: assert property (@(posedge clk) disable iff (rst) ss_n |-> !sclk);

    a_idle_hold: assert property (@(posedge clk) disable iff (rst)
        (phase == IDLE && !start) |=> phase == IDLE);

endmodule

`default_nettype wire

//--- logic/spi_lane_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module spi_lane_shifter
    import spi_flash_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  lane_ctrl_t       ctrl,
    input  logic             dq_in,
    output logic             dq_out,
    output logic             dq_oe,
    output logic [CAP_W-1:0] captured
);

    logic [DATA_W-1:0] out_q;

    assign dq_out = out_q[DATA_W-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            dq_oe <= 1'b0;
        else if (ctrl.load || ctrl.shift)
            dq_oe <= ctrl.oe_req;
    end

    // Capture restarts from a single marker bit on every load
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            out_q    <= ctrl.word;
            captured <= CAP_W'(1);
        end else begin
            if (ctrl.shift)
                out_q <= {out_q[DATA_W-2:0], 1'b0};
            if (ctrl.sample)
                captured <= {captured[CAP_W-2:0], dq_in};
        end
    end

endmodule

`default_nettype wire

//--- logic/spi_lane_merge.sv
`timescale 1ns/1ns
`default_nettype none

module spi_lane_merge
    import spi_flash_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [CAP_W-1:0]  lane_bits [NUM_LANES],
    input  lane_mode_e        lane_mode,
    input  logic              capture_done,
    output logic [DATA_W-1:0] rdata_word
);

    logic [2:0]        nbytes;
    logic [DATA_W-1:0] stream;
    logic [DATA_W-1:0] word;

    // Marker position gives the number of bytes received
    always_comb begin
        if (lane_mode == LANE_QUAD) begin
            for (int i = 0; i < DATA_W / NUM_LANES; i++)
                for (int k = 0; k < NUM_LANES; k++)
                    stream[NUM_LANES*i+k] = lane_bits[k][i];
            if (lane_bits[0][8])
                nbytes = 3'd4;
            else if (lane_bits[0][6])
                nbytes = 3'd3;
            else if (lane_bits[0][4])
                nbytes = 3'd2;
            else
                nbytes = 3'd1;
        end else begin
            // MISO sits on DQ1
            stream = lane_bits[1][DATA_W-1:0];
            if (lane_bits[1][32])
                nbytes = 3'd4;
            else if (lane_bits[1][24])
                nbytes = 3'd3;
            else if (lane_bits[1][16])
                nbytes = 3'd2;
            else
                nbytes = 3'd1;
        end
    end

    // First byte received lands in the low byte
    always_comb begin
        word = '0;
        for (int j = 0; j < DATA_W / 8; j++)
            if (j < nbytes)
                word[8*j +: 8] = stream[8*(int'(nbytes)-1-j) +: 8];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rdata_word <= '0;
        else if (capture_done)
            rdata_word <= word;
    end

endmodule

`default_nettype wire

//--- logic/spi_flash_master.sv
`timescale 1ns/1ns
`default_nettype none

module spi_flash_master
    import spi_flash_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0]     pwdata,
    input  logic [NUM_LANES-1:0]  dq_in,
    output logic [DATA_W-1:0]     prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  sclk,
    output logic                  ss_n,
    output logic [NUM_LANES-1:0]  dq_out,
    output logic [NUM_LANES-1:0]  dq_oe
);

    apb_req_t             apb;
    flash_cmd_t           cmd;
    logic [FL_ADDR_W-1:0] flash_addr;
    logic [DATA_W-1:0]    wdata_word;
    logic [DATA_W-1:0]    rdata_word;
    logic                 start;
    logic                 busy;
    logic                 done;
    lane_ctrl_t           lane_ctrl [NUM_LANES];
    lane_mode_e           lane_mode;
    logic                 capture_done;
    logic [CAP_W-1:0]     lane_bits [NUM_LANES];

    assign apb = '{psel: psel, penable: penable, pwrite: pwrite, paddr: paddr, pwdata: pwdata};

    spi_flash_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .apb        (apb),
        .busy       (busy),
        .done       (done),
        .rdata_word (rdata_word),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .cmd        (cmd),
        .flash_addr (flash_addr),
        .wdata_word (wdata_word),
        .start      (start)
    );

    spi_frame_seq u_seq (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .cmd          (cmd),
        .flash_addr   (flash_addr),
        .wdata_word   (wdata_word),
        .busy         (busy),
        .done         (done),
        .sclk         (sclk),
        .ss_n         (ss_n),
        .lane_ctrl    (lane_ctrl),
        .lane_mode    (lane_mode),
        .capture_done (capture_done)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        spi_lane_shifter u_lane (
            .clk      (clk),
            .rst      (rst),
            .ctrl     (lane_ctrl[k]),
            .dq_in    (dq_in[k]),
            .dq_out   (dq_out[k]),
            .dq_oe    (dq_oe[k]),
            .captured (lane_bits[k])
        );
    end

    spi_lane_merge u_merge (
        .clk          (clk),
        .rst          (rst),
        .lane_bits    (lane_bits),
        .lane_mode    (lane_mode),
        .capture_done (capture_done),
        .rdata_word   (rdata_word)
    );

endmodule

`default_nettype wire

//--- testbench/flash_model.sv
`timescale 1ns/1ns
`default_nettype none

module flash_model (
    input  logic       sclk,
    input  logic       ss_n,
    input  logic [3:0] dq_out,
    input  logic [3:0] dq_oe,
    output logic [3:0] dq_in
);

    logic [7:0]  opcode = '0;
    logic [23:0] addr = '0;
    logic [7:0]  wbytes [4];
    int          nwr = 0;
    int          nbits = 0;
    int          oe_errors = 0;
    logic [7:0]  shreg = '0;
    logic        quad;
    logic        rd;
    logic        wr;
    int          dummy;
    int          alen;
    int          data_start;

    // Reads are 0B and EB and programs are 02 and 38
    always_comb begin
        quad       = opcode == 8'hEB || opcode == 8'h38;
        rd         = opcode == 8'h0B || opcode == 8'hEB;
        wr         = opcode == 8'h02 || opcode == 8'h38;
        dummy      = (opcode == 8'h0B) ? 8 : (opcode == 8'hEB) ? 4 : 0;
        alen       = quad ? 6 : 24;
        data_start = 8 + alen + dummy;
    end

    function automatic logic [7:0] read_byte(input int idx);
        return (addr[7:0] + 8'(idx)) ^ 8'hA5;
    endfunction

    initial dq_in = '0;

    always @(negedge ss_n) begin
        nbits     = 0;
        nwr       = 0;
        opcode    = '0;
        addr      = '0;
        oe_errors = 0;
    end

    // Device samples on the rising edge
    always @(posedge sclk) begin
        logic [3:0] exp_oe;
        if (nbits < 8)
            exp_oe = 4'b0001;
        else if (nbits < 8 + alen || wr)
            exp_oe = quad ? 4'b1111 : 4'b0001;
        else
            exp_oe = 4'b0000;
        if (dq_oe !== exp_oe)
            oe_errors++;
        if (nbits < 8) begin
            opcode = {opcode[6:0], dq_out[0]};
        end else if (nbits < 8 + alen) begin
            addr = quad ? {addr[19:0], dq_out} : {addr[22:0], dq_out[0]};
        end else if (wr) begin
            shreg = quad ? {shreg[3:0], dq_out} : {shreg[6:0], dq_out[0]};
            if ((nbits - 8 - alen) % (quad ? 2 : 8) == (quad ? 1 : 7) && nwr < 4) begin
                wbytes[nwr] = shreg;
                nwr++;
            end
        end
        nbits++;
    end

    // Read data shifts out on the falling edge with the high nibble first in quad
    always @(negedge sclk) begin
        int         r;
        logic [7:0] b;
        r = nbits - data_start;
        if (!ss_n && rd && nbits >= 8 + alen && r >= 0) begin
            b = read_byte(quad ? r / 2 : r / 8);
            if (quad)
                dq_in = r[0] ? b[3:0] : b[7:4];
            else
                dq_in = {2'b00, b[7 - r % 8], 1'b0};
        end else begin
            dq_in = '0;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_spi_flash_master.sv
`timescale 1ns/1ns
`default_nettype none

module tb_spi_flash_master
    import spi_flash_pkg::*;
();

    localparam int APB_WAIT_LIMIT = 8;
    localparam int POLL_LIMIT     = 500;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [DATA_W-1:0]     pwdata;
    logic [DATA_W-1:0]     prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  sclk;
    logic                  ss_n;
    logic [NUM_LANES-1:0]  dq_out;
    logic [NUM_LANES-1:0]  dq_oe;
    logic [NUM_LANES-1:0]  dq_in;

    int errors;
    int tests_run;
    int tests_failed;
    int test_start_errors;

    spi_flash_master uut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .dq_in   (dq_in),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .sclk    (sclk),
        .ss_n    (ss_n),
        .dq_out  (dq_out),
        .dq_oe   (dq_oe)
    );

    flash_model flash (
        .sclk   (sclk),
        .ss_n   (ss_n),
        .dq_out (dq_out),
        .dq_oe  (dq_oe),
        .dq_in  (dq_in)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        assert (got === exp)
        else begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1)
        else begin
            $display("error: %s", what);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
    endtask

    task automatic abort_run(input string why);
        $display("error: %s", why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!pready && waited < APB_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            abort_run("APB transfer never saw pready");
        end else begin
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             output logic err);
        logic [DATA_W-1:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic write_ok(input logic [APB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic err;
        apb_write(addr, data, err);
        check_value("pslverr", DATA_W'(err), '0);
    endtask

    // Sticky done bit marks the end of the frame
    task automatic wait_done();
        logic [DATA_W-1:0] status;
        logic              err;
        int                polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < POLL_LIMIT) begin
            apb_read(REG_STATUS, status, err);
            polls++;
        end
        if (!status[1]) begin
            abort_run("frame did not finish within the poll limit");
        end else begin
            check_true(!status[0], "busy still set after done");
            check_true(flash.oe_errors == 0, "output enables wrong during the frame");
        end
    endtask

    // REG_CMD packs opcode, type, mode, dummy count and byte count minus one
    function automatic logic [DATA_W-1:0] cmd_word(input logic [7:0] opcode,
                                                  input frame_type_e ftype, input logic quad,
                                                  input int dummy, input int nbytes);
        logic [DATA_W-1:0] w;
        w        = '0;
        w[7:0]   = opcode;
        w[9:8]   = ftype;
        w[10]    = quad;
        w[14:11] = dummy[3:0];
        w[16:15] = 2'(nbytes - 1);
        return w;
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [23:0] addr, input int n);
        logic [DATA_W-1:0] w;
        w = '0;
        for (int j = 0; j < n; j++)
            w[8*j +: 8] = (addr[7:0] + 8'(j)) ^ 8'hA5;
        return w;
    endfunction

    task automatic run_frame(input logic [DATA_W-1:0] cmd_w, input logic [23:0] addr,
                             input logic [DATA_W-1:0] wdata);
        write_ok(REG_CMD, cmd_w);
        write_ok(REG_ADDR, DATA_W'(addr));
        write_ok(REG_WDATA, wdata);
        write_ok(REG_CTRL, 32'h1);
        wait_done();
    endtask

    task automatic check_read(input logic [DATA_W-1:0] cmd_w, input logic [23:0] addr,
                              input int n);
        logic [DATA_W-1:0] rdata;
        logic              err;
        run_frame(cmd_w, addr, '0);
        check_value("opcode", DATA_W'(flash.opcode), DATA_W'(cmd_w[7:0]));
        check_value("flash address", DATA_W'(flash.addr), DATA_W'(addr));
        apb_read(REG_RDATA, rdata, err);
        check_value("rdata", rdata, expected_read(addr, n));
    endtask

    task automatic check_write(input logic [DATA_W-1:0] cmd_w, input logic [23:0] addr,
                               input logic [DATA_W-1:0] data, input int n);
        run_frame(cmd_w, addr, data);
        check_value("opcode", DATA_W'(flash.opcode), DATA_W'(cmd_w[7:0]));
        check_value("flash address", DATA_W'(flash.addr), DATA_W'(addr));
        check_value("write byte count", flash.nwr, n);
        for (int j = 0; j < n; j++)
            check_value($sformatf("write byte %0d", j), DATA_W'(flash.wbytes[j]),
                        DATA_W'(data[8*j +: 8]));
    endtask

    task automatic test_reset();
        logic [DATA_W-1:0] rdata;
        logic              err;
        begin_test();
        check_value("ss_n", DATA_W'(ss_n), 32'h1);
        check_value("sclk", DATA_W'(sclk), '0);
        check_value("dq_oe", DATA_W'(dq_oe), '0);
        apb_read(REG_STATUS, rdata, err);
        check_value("status", rdata, '0);
        check_value("pslverr", DATA_W'(err), '0);
        apb_read(8'h20, rdata, err);
        check_value("pslverr", DATA_W'(err), 32'h1);
        apb_write(8'h3C, 32'h1234, err);
        check_value("pslverr", DATA_W'(err), 32'h1);
        end_test("reset and decode");
    endtask

    task automatic test_cmd_only();
        begin_test();
        run_frame(cmd_word(8'h06, FRAME_CMD, 1'b0, 0, 1), '0, '0);
        check_value("opcode", DATA_W'(flash.opcode), 32'h06);
        // Eight clocks means no address followed
        check_value("sclk count", flash.nbits, 8);
        end_test("command only");
    endtask

    task automatic test_single_read();
        logic [23:0] addr;
        begin_test();
        addr = 24'($urandom);
        check_read(cmd_word(8'h0B, FRAME_READ, 1'b0, 8, 4), addr, 4);
        end_test("single read");
    endtask

    task automatic test_quad_read();
        logic [23:0] addr;
        begin_test();
        for (int n = 1; n <= 3; n++) begin
            addr = 24'($urandom);
            check_read(cmd_word(8'hEB, FRAME_READ, 1'b1, 4, n), addr, n);
        end
        end_test("quad read");
    endtask

    task automatic test_writes();
        logic [23:0]       addr;
        logic [DATA_W-1:0] data;
        begin_test();
        addr = 24'($urandom);
        data = $urandom;
        check_write(cmd_word(8'h02, FRAME_WRITE, 1'b0, 0, 4), addr, data, 4);
        addr = 24'($urandom);
        data = $urandom;
        check_write(cmd_word(8'h38, FRAME_WRITE, 1'b1, 0, 3), addr, data, 3);
        end_test("single and quad write");
    endtask

    task automatic test_busy_start();
        logic [23:0]       addr;
        logic [DATA_W-1:0] rdata;
        logic              err;
        begin_test();
        addr = 24'($urandom);
        write_ok(REG_CMD, cmd_word(8'h0B, FRAME_READ, 1'b0, 8, 2));
        write_ok(REG_ADDR, DATA_W'(addr));
        write_ok(REG_CTRL, 32'h1);
        // Second start lands while the frame runs
        apb_write(REG_CTRL, 32'h1, err);
        check_value("pslverr", DATA_W'(err), 32'h1);
        wait_done();
        apb_read(REG_RDATA, rdata, err);
        check_value("rdata", rdata, expected_read(addr, 2));
        end_test("start while busy");
    endtask

    initial begin
        void'($urandom(17853));
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_cmd_only();
        test_single_read();
        test_quad_read();
        test_writes();
        test_busy_start();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
logic/spi_flash_pkg.sv
logic/spi_flash_regs.sv
logic/spi_frame_seq.sv
logic/spi_lane_shifter.sv
logic/spi_lane_merge.sv
logic/spi_flash_master.sv
testbench/flash_model.sv
testbench/tb_spi_flash_master.sv

//--- Bender.yml
package:
  name: spi_flash_master

sources:
  - logic/spi_flash_pkg.sv
  - logic/spi_flash_regs.sv
  - logic/spi_frame_seq.sv
  - logic/spi_lane_shifter.sv
  - logic/spi_lane_merge.sv
  - logic/spi_flash_master.sv
  - target: simulation
    files:
      - testbench/flash_model.sv
      - testbench/tb_spi_flash_master.sv
